// File: hw/game_pkg.sv
`default_nettype none

package game_pkg;

    typedef logic [7:0] xpos_t;
    typedef logic [7:0] ypos_t;
    typedef logic [2:0] rgb_t;

    // Reduced raster, not a standard video mode
    localparam xpos_t screen_width  = 8'd160;
    localparam ypos_t screen_height = 8'd120;
    localparam xpos_t h_total       = 8'd200;
    localparam ypos_t v_total       = 8'd130;
    localparam xpos_t h_sync_start  = 8'd168;
    localparam xpos_t h_sync_len    = 8'd12;
    localparam ypos_t v_sync_start  = 8'd122;
    localparam ypos_t v_sync_len    = 8'd2;

    localparam xpos_t sprite_size = 8'd8;

    typedef struct packed {
        xpos_t left;
        xpos_t right;
        ypos_t top;
        ypos_t bottom;
        logic  valid;
    } sprite_box_t;

    typedef enum logic [1:0] {state_idle, state_shoot, state_won, state_lost} game_state_t;

    localparam int          mixer_stages     = 3;
    localparam logic [15:0] end_timer_cycles = 16'd65000;

    // Colours are {r, g, b}
    localparam rgb_t colour_won  = 3'b010;
    localparam rgb_t colour_lost = 3'b100;

endpackage

`default_nettype wire

// File: hw/sprite_ctrl_if.sv
`timescale 1ns/1ns
`default_nettype none

interface sprite_ctrl_if;

    import game_pkg::*;

    // Strobes and level from the master FSM
    logic write_xy;
    logic write_dxy;
    logic enable_update;

    // Status back from the sprite engine
    logic        within_screen;
    sprite_box_t box;

    modport fsm
    (
        output write_xy,
        output write_dxy,
        output enable_update,
        input  within_screen,
        input  box
    );

    modport sprite
    (
        input  write_xy,
        input  write_dxy,
        input  enable_update,
        output within_screen,
        output box
    );

endinterface

`default_nettype wire

// File: hw/raster_timing.sv
`timescale 1ns/1ns
`default_nettype none

module raster_timing
(
    input  wire             clk,
    input  wire             reset,
    output logic            hsync,
    output logic            vsync,
    output logic            display_on,
    output logic            end_of_frame,
    output game_pkg::xpos_t pixel_x,
    output game_pkg::ypos_t pixel_y
);

    import game_pkg::*;

    xpos_t h_count;
    ypos_t v_count;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            h_count <= '0;
            v_count <= '0;
        end
        else if (h_count == h_total - 1'b1)
        begin
            h_count <= '0;
            v_count <= (v_count == v_total - 1'b1) ? '0 : v_count + 1'b1;
        end
        else
        begin
            h_count <= h_count + 1'b1;
        end
    end

    // Registered, so these trail the counters by one clock like the sprite pixels
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            hsync      <= 1'b0;
            vsync      <= 1'b0;
            display_on <= 1'b0;
        end
        else
        begin
            hsync      <= h_count >= h_sync_start && h_count < h_sync_start + h_sync_len;
            vsync      <= v_count >= v_sync_start && v_count < v_sync_start + v_sync_len;
            display_on <= h_count < screen_width && v_count < screen_height;
        end
    end

    assign end_of_frame = h_count == h_total - 1'b1 && v_count == v_total - 1'b1;
    assign pixel_x      = h_count;
    assign pixel_y      = v_count;

endmodule

`default_nettype wire

// File: hw/game_random.sv
`timescale 1ns/1ns
`default_nettype none

module game_random
(
    input  wire         clk,
    input  wire         reset,
    output logic [15:0] random
);

    // Galois form of x^16 + x^14 + x^13 + x^11 + 1
    always_ff @(posedge clk)
    begin
        if (reset)
            random <= 16'hace1;
        else
            random <= {1'b0, random[15:1]} ^ (random[0] ? 16'hb400 : 16'h0000);
    end

endmodule

`default_nettype wire

// File: hw/game_sprite.sv
`timescale 1ns/1ns
`default_nettype none

module game_sprite
#(
    parameter type              delta_x_t = logic signed [1:0],
    parameter type              delta_y_t = logic signed [1:0],
    parameter logic [0:7][31:0] image     = {8{32'h7777_7777}}
)
(
    input  wire                  clk,
    input  wire                  reset,
    sprite_ctrl_if.sprite        ctrl,
    input  wire                  end_of_frame,
    input  wire game_pkg::xpos_t pixel_x,
    input  wire game_pkg::ypos_t pixel_y,
    input  wire game_pkg::xpos_t write_x,
    input  wire game_pkg::ypos_t write_y,
    input  wire delta_x_t        write_dx,
    input  wire delta_y_t        write_dy,
    output logic                 rgb_en,
    output game_pkg::rgb_t       rgb
);

    import game_pkg::*;

    xpos_t       x;
    ypos_t       y;
    delta_x_t    dx;
    delta_y_t    dy;
    logic        active;
    xpos_t       rel_x;
    ypos_t       rel_y;
    logic [31:0] row;
    logic [3:0]  nibble;
    logic        hit;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            x      <= '0;
            y      <= '0;
            dx     <= '0;
            dy     <= '0;
            active <= 1'b0;
        end
        else
        begin
            if (ctrl.write_xy)
            begin
                x <= write_x;
                y <= write_y;
            end
            else if (ctrl.enable_update && end_of_frame)
            begin
                // Velocity is signed, the casts sign-extend it
                x <= x + xpos_t'(dx);
                y <= y + ypos_t'(dy);
            end

            if (ctrl.write_dxy)
            begin
                dx <= write_dx;
                dy <= write_dy;
            end

            // Visible from the load until the FSM stops the motion
            if (ctrl.write_xy)
                active <= 1'b1;
            else if (!ctrl.enable_update)
                active <= 1'b0;
        end
    end

    assign ctrl.box = '{left:   x,
                        right:  x + (sprite_size - 1'b1),
                        top:    y,
                        bottom: y + (sprite_size - 1'b1),
                        valid:  active};

    // A wrap past zero shows up as a large coordinate
    assign ctrl.within_screen = x <= screen_width - sprite_size
                             && y <= screen_height - sprite_size;

    assign rel_x  = pixel_x - x;
    assign rel_y  = pixel_y - y;
    assign row    = image[rel_y[2:0]];
    assign nibble = row[{~rel_x[2:0], 2'b00} +: 4];
    assign hit    = active && rel_x < sprite_size && rel_y < sprite_size;

    always_ff @(posedge clk)
    begin
        if (reset)
            rgb_en <= 1'b0;
        else
            rgb_en <= hit && nibble != 4'h0;
    end

    always_ff @(posedge clk)
        rgb <= nibble[2:0];

endmodule

`default_nettype wire

// File: hw/game_overlap.sv
`timescale 1ns/1ns
`default_nettype none

module game_overlap
(
    input  wire                        clk,
    input  wire                        reset,
    input  wire game_pkg::sprite_box_t box_a,
    input  wire game_pkg::sprite_box_t box_b,
    output logic                       overlap
);

    always_ff @(posedge clk)
    begin
        if (reset)
            overlap <= 1'b0;
        else
            overlap <= box_a.valid && box_b.valid
                    && box_a.left <= box_b.right  && box_b.left <= box_a.right
                    && box_a.top  <= box_b.bottom && box_b.top  <= box_a.bottom;
    end

endmodule

`default_nettype wire

// File: hw/game_master_fsm.sv
`timescale 1ns/1ns
`default_nettype none

module game_master_fsm
(
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   key,
    sprite_ctrl_if.fsm            target,
    sprite_ctrl_if.fsm            torpedo,
    input  wire                   collision,
    output game_pkg::game_state_t game_state
);

    import game_pkg::*;

    game_state_t state;
    logic        load_strobe;
    logic [15:0] timer;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state       <= state_idle;
            load_strobe <= 1'b0;
            timer       <= '0;
        end
        else
        begin
            load_strobe <= 1'b0;

            case (state)
            state_idle:
                if (key)
                begin
                    state       <= state_shoot;
                    load_strobe <= 1'b1;
                end

            state_shoot:
                if (collision)
                begin
                    state <= state_won;
                    timer <= end_timer_cycles - 1'b1;
                end
                // Screen status is stale until the load strobe has been taken
                else if (!load_strobe && (!target.within_screen || !torpedo.within_screen))
                begin
                    state <= state_lost;
                    timer <= end_timer_cycles - 1'b1;
                end

            state_won, state_lost:
                if (timer == '0)
                    state <= state_idle;
                else
                    timer <= timer - 1'b1;

            default:
                state <= state_idle;
            endcase
        end
    end

    // Both sprites are launched together
    assign target.write_xy       = load_strobe;
    assign target.write_dxy      = load_strobe;
    assign torpedo.write_xy      = load_strobe;
    assign torpedo.write_dxy     = load_strobe;

    assign target.enable_update  = state == state_shoot;
    assign torpedo.enable_update = state == state_shoot;

    assign game_state = state;

endmodule

`default_nettype wire

// File: hw/game_mixer.sv
`timescale 1ns/1ns
`default_nettype none

module game_mixer
(
    input  wire                        clk,
    input  wire                        reset,
    input  wire                        display_on,
    input  wire                        hsync_in,
    input  wire                        vsync_in,
    input  wire                        target_en,
    input  wire game_pkg::rgb_t        target_rgb,
    input  wire                        torpedo_en,
    input  wire game_pkg::rgb_t        torpedo_rgb,
    input  wire game_pkg::game_state_t game_state,
    output game_pkg::rgb_t             rgb,
    output logic                       hsync,
    output logic                       vsync
);

    import game_pkg::*;

    rgb_t                        colour;
    rgb_t [mixer_stages - 1:0]   rgb_pipe;
    logic [mixer_stages - 1:0]   hsync_pipe;
    logic [mixer_stages - 1:0]   vsync_pipe;

    always_comb
    begin
        if (!display_on)
            colour = '0;
        else if (game_state == state_won)
            colour = colour_won;
        else if (game_state == state_lost)
            colour = colour_lost;
        else if (torpedo_en)
            colour = torpedo_rgb;
        else if (target_en)
            colour = target_rgb;
        else
            colour = '0;
    end

    // Colour and syncs share one pipeline to stay aligned
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rgb_pipe   <= '0;
            hsync_pipe <= '0;
            vsync_pipe <= '0;
        end
        else
        begin
            rgb_pipe   <= {rgb_pipe[mixer_stages - 2:0], colour};
            hsync_pipe <= {hsync_pipe[mixer_stages - 2:0], hsync_in};
            vsync_pipe <= {vsync_pipe[mixer_stages - 2:0], vsync_in};
        end
    end

    assign rgb   = rgb_pipe[mixer_stages - 1];
    assign hsync = hsync_pipe[mixer_stages - 1];
    assign vsync = vsync_pipe[mixer_stages - 1];

endmodule

`default_nettype wire

// File: hw/game_top.sv
`timescale 1ns/1ns
`default_nettype none

module game_top
(
    input  wire             clk,
    input  wire             reset,
    input  wire             key,
    input  wire [1:0]       sw,
    output logic            hsync,
    output logic            vsync,
    output game_pkg::rgb_t  rgb
);

    import game_pkg::*;

    typedef logic signed [1:0] dx_t;
    typedef logic signed [0:0] target_dy_t;
    typedef logic signed [2:0] torpedo_dy_t;

    logic        raster_hsync;
    logic        raster_vsync;
    logic        display_on;
    logic        end_of_frame;
    xpos_t       pixel_x;
    ypos_t       pixel_y;
    logic [15:0] random;

    xpos_t       target_x;
    ypos_t       target_y;
    dx_t         target_dx;
    target_dy_t  target_dy;
    logic        target_en;
    rgb_t        target_rgb;

    xpos_t       torpedo_x;
    ypos_t       torpedo_y;
    dx_t         torpedo_dx;
    torpedo_dy_t torpedo_dy;
    logic        torpedo_en;
    rgb_t        torpedo_rgb;

    logic        collision;
    game_state_t game_state;

    sprite_ctrl_if target_ctrl ();
    sprite_ctrl_if torpedo_ctrl ();

    raster_timing raster
    (
        .clk          ( clk          ),
        .reset        ( reset        ),
        .hsync        ( raster_hsync ),
        .vsync        ( raster_vsync ),
        .display_on   ( display_on   ),
        .end_of_frame ( end_of_frame ),
        .pixel_x      ( pixel_x      ),
        .pixel_y      ( pixel_y      )
    );

    game_random random_generator
    (
        .clk    ( clk    ),
        .reset  ( reset  ),
        .random ( random )
    );

    // Target enters from the left moving right, or from the right moving left
    always_comb
    begin
        if (random[7])
        begin
            target_x  = '0;
            target_dx = 2'sb01;
        end
        else
        begin
            target_x  = screen_width - sprite_size;
            target_dx = {1'b1, random[6]};
        end
    end

    assign target_y  = screen_height / 8'd10 + {2'b00, random[5:0]};
    assign target_dy = '0;

    // Torpedo starts bottom centre, switches pick the drift
    assign torpedo_x  = (screen_width >> 1) - (sprite_size >> 1);
    assign torpedo_y  = screen_height - (sprite_size << 1);
    assign torpedo_dy = (sw == 2'b00) ? 3'sb111 : 3'sb110;

    always_comb
    begin
        case (sw)
        2'b01:   torpedo_dx = 2'sb01;
        2'b10:   torpedo_dx = 2'sb11;
        default: torpedo_dx = 2'sb00;
        endcase
    end

    game_sprite
    #(
        .delta_x_t ( dx_t        ),
        .delta_y_t ( target_dy_t ),
        .image     ( {32'h000bb000, 32'h00099000, 32'h00099000, 32'hb99ff99b,
                      32'hb99ff99b, 32'h00099000, 32'h00099000, 32'h000bb000} )
    )
    sprite_target
    (
        .clk          ( clk          ),
        .reset        ( reset        ),
        .ctrl         ( target_ctrl  ),
        .end_of_frame ( end_of_frame ),
        .pixel_x      ( pixel_x      ),
        .pixel_y      ( pixel_y      ),
        .write_x      ( target_x     ),
        .write_y      ( target_y     ),
        .write_dx     ( target_dx    ),
        .write_dy     ( target_dy    ),
        .rgb_en       ( target_en    ),
        .rgb          ( target_rgb   )
    );

    game_sprite
    #(
        .delta_x_t ( dx_t         ),
        .delta_y_t ( torpedo_dy_t ),
        .image     ( {32'h000cc000, 32'h00cccc00, 32'h0cceecc0, 32'hcccccccc,
                      32'hcc0cc0cc, 32'hcc0cc0cc, 32'hcc0cc0cc, 32'hcc0cc0cc} )
    )
    sprite_torpedo
    (
        .clk          ( clk          ),
        .reset        ( reset        ),
        .ctrl         ( torpedo_ctrl ),
        .end_of_frame ( end_of_frame ),
        .pixel_x      ( pixel_x      ),
        .pixel_y      ( pixel_y      ),
        .write_x      ( torpedo_x    ),
        .write_y      ( torpedo_y    ),
        .write_dx     ( torpedo_dx   ),
        .write_dy     ( torpedo_dy   ),
        .rgb_en       ( torpedo_en   ),
        .rgb          ( torpedo_rgb  )
    );

    game_overlap overlap
    (
        .clk     ( clk              ),
        .reset   ( reset            ),
        .box_a   ( target_ctrl.box  ),
        .box_b   ( torpedo_ctrl.box ),
        .overlap ( collision        )
    );

    game_master_fsm master_fsm
    (
        .clk        ( clk          ),
        .reset      ( reset        ),
        .key        ( key          ),
        .target     ( target_ctrl  ),
        .torpedo    ( torpedo_ctrl ),
        .collision  ( collision    ),
        .game_state ( game_state   )
    );

    game_mixer mixer
    (
        .clk         ( clk          ),
        .reset       ( reset        ),
        .display_on  ( display_on   ),
        .hsync_in    ( raster_hsync ),
        .vsync_in    ( raster_vsync ),
        .target_en   ( target_en    ),
        .target_rgb  ( target_rgb   ),
        .torpedo_en  ( torpedo_en   ),
        .torpedo_rgb ( torpedo_rgb  ),
        .game_state  ( game_state   ),
        .rgb         ( rgb          ),
        .hsync       ( hsync        ),
        .vsync       ( vsync        )
    );

endmodule

`default_nettype wire

// File: verif/game_sva.sv
`timescale 1ns/1ns
`default_nettype none

module game_sva
(
    input wire                 clk,
    input wire                 reset,
    input wire                 display_on,
    input wire game_pkg::rgb_t rgb,
    input wire                 target_write_xy,
    input wire                 target_write_dxy,
    input wire                 torpedo_write_xy,
    input wire                 torpedo_write_dxy
);

    logic [3:0] strobes;

    assign strobes = {target_write_xy, target_write_dxy, torpedo_write_xy, torpedo_write_dxy};

    // Mixer output trails display_on by three clocks
    blank_is_black: assert property (@(posedge clk) disable iff (reset)
        !$past(display_on, 3) |-> rgb == '0)
        else $error("rgb not black during blanking");

    strobe_single_cycle: assert property (@(posedge clk) disable iff (reset)
        strobes != '0 |=> strobes == '0)
        else $error("load strobe longer than one cycle");

    strobe_low_in_reset: assert property (@(posedge clk)
        reset && $past(reset) |-> strobes == '0)
        else $error("load strobe high during reset");

endmodule

`default_nettype wire

// File: verif/tb_game_top.sv
`timescale 1ns/1ns
`default_nettype none

module tb_game_top;

    import game_pkg::*;

    localparam int cls_black  = 0;
    localparam int cls_play   = 1;
    localparam int cls_result = 2;

    // Raster leaves reset after three clocks, output syncs lag by four
    localparam int first_hsync_cycle = 3 + 168 + 4;

    logic       clk;
    logic       reset;
    logic       key;
    logic [1:0] sw;
    logic       hsync;
    logic       vsync;
    rgb_t       rgb;

    string      phase_name [16];
    int         phase_frames [16];
    logic       phase_key [16];
    logic [1:0] phase_sw [16];
    int         phase_class [16];
    int         num_phases;

    int   cycles;
    int   cycle_limit;
    int   errors;
    int   printed;
    int   tests_failed;
    int   frame_count;
    bit   aligned;
    logic hsync_q;
    int   ref_h;
    int   ref_v;
    int   cur_class;
    bit   torpedo_seen;
    int   res_state;
    rgb_t res_colour;
    int   res_start;
    rgb_t line_colour;
    bit   line_uniform;

    game_top dut0
    (
        .clk   ( clk   ),
        .reset ( reset ),
        .key   ( key   ),
        .sw    ( sw    ),
        .hsync ( hsync ),
        .vsync ( vsync ),
        .rgb   ( rgb   )
    );

    bind game_top game_sva sva0
    (
        .clk               ( clk                    ),
        .reset             ( reset                  ),
        .display_on        ( display_on             ),
        .rgb               ( rgb                    ),
        .target_write_xy   ( target_ctrl.write_xy   ),
        .target_write_dxy  ( target_ctrl.write_dxy  ),
        .torpedo_write_xy  ( torpedo_ctrl.write_xy  ),
        .torpedo_write_dxy ( torpedo_ctrl.write_dxy )
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic report_mismatch(input string name, input int got, input int exp);
        errors++;
        if (printed < 30)
            $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
        printed++;
    endtask

    task automatic check_rgb(input string name, input rgb_t got, input rgb_t exp);
        if (got !== exp)
            report_mismatch(name, int'(got), int'(exp));
    endtask

    task automatic check_sync(input string name, input logic got, input logic exp);
        if (got !== exp)
            report_mismatch(name, int'(got), int'(exp));
    endtask

    // Target nibbles b, 9, f and torpedo nibbles c, e keep their low three bits
    function automatic bit is_play_colour(input rgb_t c);
        return c == 3'd0 || c == 3'd1 || c == 3'd3 || c == 3'd7 || c == 3'd4 || c == 3'd6;
    endfunction

    task automatic check_class(input rgb_t got, input int cls);
        if (cls == cls_black)
            check_rgb("rgb", got, 3'd0);
        else if (cls == cls_play)
        begin
            if (!is_play_colour(got))
                report_mismatch("rgb class play", int'(got), 0);
            if (ref_v >= 104 && (got == 3'd4 || got == 3'd6))
                torpedo_seen = 1'b1;
        end
        else if (res_state == 0)
        begin
            if (!is_play_colour(got) && got != colour_won)
                report_mismatch("rgb before result", int'(got), 0);
            if (ref_h == 0)
            begin
                line_colour  = got;
                line_uniform = 1'b1;
            end
            else if (got != line_colour)
                line_uniform = 1'b0;
            // A full line of one result colour marks the end of the game
            if (ref_h == 159 && line_uniform && (line_colour == colour_won
                                                 || line_colour == colour_lost))
            begin
                res_state  = 1;
                res_colour = line_colour;
                res_start  = cycles;
            end
        end
        else if (res_state == 1)
        begin
            if (got == 3'd0)
            begin
                res_state = 2;
                if (cycles - res_start < 64000 || cycles - res_start > 68000)
                begin
                    $display("Result colour lasted %0d clocks, not about %0d",
                             cycles - res_start, end_timer_cycles);
                    errors++;
                end
            end
            else
                check_rgb("rgb result", got, res_colour);
        end
        else
            check_rgb("rgb after result", got, 3'd0);
    endtask

    // Reference raster, sampled away from the driving edge
    always @(negedge clk)
    begin
        if (aligned)
        begin
            ref_h = ref_h + 1;
            if (ref_h == 200)
            begin
                ref_h = 0;
                ref_v = (ref_v == 129) ? 0 : ref_v + 1;
            end
            if (ref_h == 0 && ref_v == 0)
                frame_count++;
            check_sync("hsync", hsync, ref_h >= 168 && ref_h < 180);
            check_sync("vsync", vsync, ref_v >= 122 && ref_v < 124);
            if (ref_h < 160 && ref_v < 120)
                check_class(rgb, cur_class);
            else
                check_rgb("rgb", rgb, 3'd0);
        end
        else if (!reset && hsync === 1'b1 && hsync_q === 1'b0)
        begin
            aligned = 1'b1;
            ref_h   = 168;
            ref_v   = 0;
            if (cycles != first_hsync_cycle)
                report_mismatch("first hsync rise cycle", cycles, first_hsync_cycle);
        end
        else if (cycles > 0)
        begin
            // Outputs stay low from reset until the first hsync
            check_sync("hsync", hsync, 1'b0);
            check_sync("vsync", vsync, 1'b0);
            check_rgb("rgb", rgb, 3'd0);
        end
        hsync_q = hsync;
    end

    always @(posedge clk)
        cycles++;

    initial
    begin
        @(posedge clk);
        wait (cycles > cycle_limit);
        $display("Timeout after %0d cycles", cycles);
        $display("Test failures found");
        $finish;
    end

    task automatic read_stimulus();
        int    fd;
        string line;
        string name;
        string cls;
        int    frames;
        int    k;
        int    s;
        fd = $fopen("verif/game_stim.txt", "r");
        if (fd == 0)
        begin
            $display("Cannot open the stimulus file");
            errors++;
        end
        else
        begin
            while (!$feof(fd) && num_phases < 16)
            begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line[0] != "#"
                    && $sscanf(line, "%s %d %h %h %s", name, frames, k, s, cls) == 5)
                begin
                    phase_name[num_phases]   = name;
                    phase_frames[num_phases] = frames;
                    phase_key[num_phases]    = k[0];
                    phase_sw[num_phases]     = s[1:0];
                    phase_class[num_phases]  = (cls == "black") ? cls_black
                                             : (cls == "play") ? cls_play : cls_result;
                    cycle_limit += frames * 26000 * 12 / 10;
                    num_phases++;
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic wait_frames(input int n);
        int start;
        start = frame_count;
        while (frame_count < start + n)
            @(posedge clk);
    endtask

    task automatic run_phase(input int p);
        int  err_start;
        bit  ok;
        err_start = errors;
        wait_frames(1);
        cur_class    = phase_class[p];
        torpedo_seen = 1'b0;
        res_state    = 0;
        sw          <= phase_sw[p];
        if (phase_key[p])
            repeat ($urandom % 50) @(posedge clk);
        key <= phase_key[p];
        wait_frames(phase_frames[p] - 1);
        ok = errors == err_start;
        if (cur_class == cls_play && !torpedo_seen)
        begin
            $display("No torpedo pixel in the bottom lines");
            ok = 1'b0;
        end
        if (cur_class == cls_result && res_state != 2)
        begin
            $display("Game did not show a result and return to idle");
            ok = 1'b0;
        end
        if (!ok)
            tests_failed++;
        $display("Phase %s: %s", phase_name[p], ok ? "ok" : "FAILED");
    endtask

    initial
    begin
        void'($urandom(32'hd774_763c));
        reset       = 1'b1;
        key         = 1'b0;
        sw          = 2'b00;
        cycles      = 0;
        cycle_limit = 0;
        num_phases  = 0;
        errors      = 0;
        printed     = 0;
        frame_count = 0;
        aligned     = 1'b0;
        cur_class   = cls_black;
        read_stimulus();
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        for (int p = 0; p < num_phases; p++)
            run_phase(p);
        $display("Phases: %0d, failed: %0d, errors: %0d", num_phases, tests_failed, errors);
        if (tests_failed == 0 && errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/game_stim.txt
# phase  frames  key  sw  class
# class is black, play or result; key and sw are hex
idle0     3   0 0 black
launch0   2   1 0 play
flight0 115   0 0 result
idle1     2   0 0 black
launch1   2   1 1 play
flight1  60   0 1 result
idle2     2   0 0 black

// File: flist.f
hw/game_pkg.sv
hw/sprite_ctrl_if.sv
hw/raster_timing.sv
hw/game_random.sv
hw/game_sprite.sv
hw/game_overlap.sv
hw/game_master_fsm.sv
hw/game_mixer.sv
hw/game_top.sv
verif/game_sva.sv
verif/tb_game_top.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -j 0
TOP       ?= tb_game_top
FLIST     ?= flist.f

SOURCES := $(shell cat $(FLIST))
BINARY  := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BINARY): $(SOURCES) $(FLIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: $(BINARY)
	./$(BINARY) | tee /dev/stderr | grep -q "All tests passed!"

clean:
	rm -rf obj_dir
